// File: lfps_pkg.sv
// lfps shared types, receive windows and send durations for a 62.5 MHz slow clock
`default_nettype none

package lfps_pkg;

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef logic [23:0] lfps_count_t;	// cycle count for widths and intervals

	localparam lfps_count_t count_max = '1;	// saturation point

	typedef enum logic [1:0] {
		pd_p0,	// active, tx running
		pd_p1,
		pd_p2,
		pd_p3	// deep sleep
	} power_state_e;

	typedef enum logic [2:0] {
		cls_none,	// width outside every window
		cls_poll,
		cls_u1,
		cls_u2lb,
		cls_u3
	} lfps_class_e;

	typedef enum logic [1:0] {
		tx_idle,
		tx_burst,
		tx_gap
	} tx_state_e;

	typedef enum logic {
		mt_idle,
		mt_burst
	} meter_state_e;

	//////////////////////////////////////////////////
	// receive windows, inclusive, in slow_clk cycles
	//////////////////////////////////////////////////

	// windows do not overlap
	localparam lfps_count_t poll_width_min = 24'd37;		// 0.6 us
	localparam lfps_count_t poll_width_max = 24'd86;		// just under 1.4 us
	localparam lfps_count_t u1_width_min = 24'd87;
	localparam lfps_count_t u1_width_max = 24'd4999;
	localparam lfps_count_t u2lb_width_min = 24'd5000;		// 80 us
	localparam lfps_count_t u2lb_width_max = 24'd124999;	// just under 2 ms
	localparam lfps_count_t u3_width_min = 24'd125000;
	localparam lfps_count_t u3_width_max = 24'd624999;	// just under 10 ms

	// spacing between two polling bursts, end to end
	localparam lfps_count_t poll_repeat_min = 24'd375;	// 6 us
	localparam lfps_count_t poll_repeat_max = 24'd874;	// 14 us

	//////////////////////////////////////////////////
	// send durations
	//////////////////////////////////////////////////

	localparam lfps_count_t send_poll_width = 24'd62;		// 1 us nominal
	localparam lfps_count_t send_poll_period = 24'd625;	// 10 us repeat

	// exit signalling is one long burst, the period only adds a cycle of gap
	localparam lfps_count_t send_u1_width = 24'd62500;	// 1 ms
	localparam lfps_count_t send_u1_period = send_u1_width + 24'd1;
	localparam lfps_count_t send_u2lb_width = 24'd62500;
	localparam lfps_count_t send_u2lb_period = send_u2lb_width + 24'd1;
	localparam lfps_count_t send_u3_width = 24'd62500;
	localparam lfps_count_t send_u3_period = send_u3_width + 24'd1;

endpackage

`default_nettype wire

// File: lfps_burst_if.sv
// lfps burst measurement channel from the burst meter to the receive decoder
`default_nettype none

interface lfps_burst_if import lfps_pkg::*; ();

	logic burst_done;			// one cycle strobe, payload valid with it
	lfps_count_t burst_width;	// low samples in the burst
	lfps_count_t burst_interval;	// end of previous burst to end of this one
	logic interval_valid;		// low on the first burst after reset

	modport meter (
		output burst_done,
		output burst_width,
		output burst_interval,
		output interval_valid
	);

	modport decoder (
		input burst_done,
		input burst_width,
		input burst_interval,
		input interval_valid
	);

endinterface

`default_nettype wire

// File: lfps_burst_meter.sv
// lfps burst meter, times each rx burst and the spacing between burst ends
`default_nettype none

module lfps_burst_meter import lfps_pkg::*; (
	input logic slow_clk,
	input logic lfps_send_reset_local,
	input logic port_rx_elecidle,
	input logic port_rx_valid,
	lfps_burst_if.meter burst
);

	meter_state_e state;
	lfps_count_t width_cnt;
	lfps_count_t interval_cnt;
	logic seen_end;		// a burst has ended since reset
	logic burst_start;
	logic burst_end;

	// line goes active without valid data -> lfps, not a pipe transfer
	assign burst_start = (state == mt_idle) && !port_rx_elecidle && !port_rx_valid;
	assign burst_end = (state == mt_burst) && port_rx_elecidle;

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////

	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			state <= mt_idle;
			seen_end <= 1'b0;
			burst.burst_done <= 1'b0;
		end else begin
			burst.burst_done <= burst_end;
			if (burst_start) begin
				state <= mt_burst;
			end
			if (burst_end) begin
				state <= mt_idle;
				seen_end <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// counters and measurement
	//////////////////////////////////////////////////

	always_ff @(posedge slow_clk) begin
		// interval restarts at every burst end
		if (burst_end) begin
			interval_cnt <= lfps_count_t'(1);
		end else if (interval_cnt != count_max) begin
			interval_cnt <= interval_cnt + 1'b1;
		end

		// first low sample counts as one
		if (burst_start) begin
			width_cnt <= lfps_count_t'(1);
		end else if ((state == mt_burst) && !port_rx_elecidle) begin
			if (width_cnt != count_max) begin
				width_cnt <= width_cnt + 1'b1;	// saturate on stuck line
			end
		end

		if (burst_end) begin
			burst.burst_width <= width_cnt;
			burst.burst_interval <= interval_cnt;
			burst.interval_valid <= seen_end;	// nothing to measure from on the first one
		end
	end

endmodule

`default_nettype wire

// File: lfps_rx_decoder.sv
// lfps receive decoder, classifies measured bursts and pulses the rx indications
`default_nettype none

module lfps_rx_decoder import lfps_pkg::*; (
	input logic slow_clk,
	input logic lfps_send_reset_local,
	lfps_burst_if.decoder burst,
	output logic lfps_recv_active,
	output logic lfps_recv_poll,
	output logic lfps_recv_u1,
	output logic lfps_recv_u2lb,
	output logic lfps_recv_u3
);

	lfps_class_e burst_class;
	logic poll_seen;		// last burst was polling width
	logic poll_repeat;		// second polling burst at the right spacing

	//////////////////////////////////////////////////
	// width classification
	//////////////////////////////////////////////////

	always_comb begin
		burst_class = cls_none;
		if ((burst.burst_width >= poll_width_min) && (burst.burst_width <= poll_width_max)) begin
			burst_class = cls_poll;
		end else if ((burst.burst_width >= u1_width_min) &&
				(burst.burst_width <= u1_width_max)) begin
			burst_class = cls_u1;
		end else if ((burst.burst_width >= u2lb_width_min) &&
				(burst.burst_width <= u2lb_width_max)) begin
			burst_class = cls_u2lb;
		end else if ((burst.burst_width >= u3_width_min) &&
				(burst.burst_width <= u3_width_max)) begin
			burst_class = cls_u3;
		end
	end

	// polling only counts once it repeats
	always_comb begin
		poll_repeat = poll_seen && burst.interval_valid &&
			(burst.burst_interval >= poll_repeat_min) &&
			(burst.burst_interval <= poll_repeat_max);
	end

	//////////////////////////////////////////////////
	// indications
	//////////////////////////////////////////////////

	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			poll_seen <= 1'b0;
			lfps_recv_active <= 1'b0;
			lfps_recv_poll <= 1'b0;
			lfps_recv_u1 <= 1'b0;
			lfps_recv_u2lb <= 1'b0;
			lfps_recv_u3 <= 1'b0;
		end else begin
			// pulses are one cycle wide
			lfps_recv_active <= 1'b0;
			lfps_recv_poll <= 1'b0;
			lfps_recv_u1 <= 1'b0;
			lfps_recv_u2lb <= 1'b0;
			lfps_recv_u3 <= 1'b0;

			if (burst.burst_done) begin
				poll_seen <= (burst_class == cls_poll);	// anything else breaks the pair
				unique case (burst_class)
					cls_poll: begin
						if (poll_repeat) begin
							lfps_recv_active <= 1'b1;
							lfps_recv_poll <= 1'b1;
						end
					end
					cls_u1: begin
						lfps_recv_active <= 1'b1;
						lfps_recv_u1 <= 1'b1;
					end
					cls_u2lb: begin
						lfps_recv_active <= 1'b1;
						lfps_recv_u2lb <= 1'b1;
					end
					cls_u3: begin
						lfps_recv_active <= 1'b1;
						lfps_recv_u3 <= 1'b1;
					end
					default: begin
						// invalid width, no indication
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: lfps_tx.sv
// lfps transmitter, picks the highest priority request and sends burst plus gap
`default_nettype none

module lfps_tx import lfps_pkg::*; (
	input logic slow_clk,
	input logic lfps_send_reset_local,
	input logic port_rx_elecidle,
	input power_state_e port_power_state,
	input logic lfps_send_poll,
	input logic lfps_send_u1,
	input logic lfps_send_u2lb,
	input logic lfps_send_u3,
	output logic lfps_send_ack,
	output logic port_tx_elecidle,
	output logic port_tx_detrx_lpbk
);

	tx_state_e state;
	lfps_count_t burst_cnt;		// cycles of burst left
	lfps_count_t period_cnt;	// cycles until ack
	lfps_count_t sel_width;
	lfps_count_t sel_period;
	logic req_any;
	logic accept;

	//////////////////////////////////////////////////
	// request priority
	//////////////////////////////////////////////////

	always_comb begin
		req_any = lfps_send_poll | lfps_send_u1 | lfps_send_u2lb | lfps_send_u3;
		sel_width = send_u3_width;
		sel_period = send_u3_period;
		if (lfps_send_poll) begin
			sel_width = send_poll_width;
			sel_period = send_poll_period;
		end else if (lfps_send_u1) begin
			sel_width = send_u1_width;
			sel_period = send_u1_period;
		end else if (lfps_send_u2lb) begin
			sel_width = send_u2lb_width;
			sel_period = send_u2lb_period;
		end
	end

	// line must be quiet, and skip the ack cycle so a stale request is not taken
	assign accept = (state == tx_idle) && req_any && port_rx_elecidle && !lfps_send_ack;

	//////////////////////////////////////////////////
	// fsm
	//////////////////////////////////////////////////

	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			state <= tx_idle;
			lfps_send_ack <= 1'b0;
		end else begin
			lfps_send_ack <= 1'b0;
			unique case (state)
				tx_idle: begin
					if (accept) begin
						state <= tx_burst;
					end
				end
				tx_burst: begin
					if (burst_cnt == lfps_count_t'(1)) begin
						state <= tx_gap;
					end
				end
				tx_gap: begin
					// period runs from the first burst cycle
					if (period_cnt == lfps_count_t'(1)) begin
						lfps_send_ack <= 1'b1;
						state <= tx_idle;
					end
				end
				default: begin
					state <= tx_idle;
				end
			endcase
		end
	end

	// both counters load together, period keeps running through the burst
	always_ff @(posedge slow_clk) begin
		if (accept) begin
			burst_cnt <= sel_width;
			period_cnt <= sel_period;
		end else if (state != tx_idle) begin
			burst_cnt <= burst_cnt - 1'b1;
			period_cnt <= period_cnt - 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// phy drive
	//////////////////////////////////////////////////

	always_comb begin
		port_tx_elecidle = 1'b1;
		port_tx_detrx_lpbk = 1'b0;
		if (state == tx_burst) begin
			if (port_power_state == pd_p0) begin
				port_tx_detrx_lpbk = 1'b1;	// p0 sends lfps through the detect/loopback pin
			end else begin
				port_tx_elecidle = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: lfps_top.sv
// lfps engine top level, rx burst meter and decoder plus the lfps transmitter
`default_nettype none

module lfps_top import lfps_pkg::*; (
	input logic slow_clk,
	input logic lfps_send_reset_local,

	// pipe rx status
	input logic port_rx_elecidle,
	input logic port_rx_valid,
	input logic [1:0] port_power_state,

	// send requests, level until ack
	input logic lfps_send_poll,
	input logic lfps_send_u1,
	input logic lfps_send_u2lb,
	input logic lfps_send_u3,

	output logic lfps_send_ack,
	output logic port_tx_elecidle,
	output logic port_tx_detrx_lpbk,

	// receive indications
	output logic lfps_recv_active,
	output logic lfps_recv_poll,
	output logic lfps_recv_u1,
	output logic lfps_recv_u2lb,
	output logic lfps_recv_u3
);

	lfps_burst_if u_burst_if ();

	lfps_burst_meter u_meter (
		.slow_clk (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.port_rx_elecidle (port_rx_elecidle),
		.port_rx_valid (port_rx_valid),
		.burst (u_burst_if.meter)
	);

	lfps_rx_decoder u_decoder (
		.slow_clk (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.burst (u_burst_if.decoder),
		.lfps_recv_active (lfps_recv_active),
		.lfps_recv_poll (lfps_recv_poll),
		.lfps_recv_u1 (lfps_recv_u1),
		.lfps_recv_u2lb (lfps_recv_u2lb),
		.lfps_recv_u3 (lfps_recv_u3)
	);

	lfps_tx u_tx (
		.slow_clk (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.port_rx_elecidle (port_rx_elecidle),
		.port_power_state (power_state_e'(port_power_state)),
		.lfps_send_poll (lfps_send_poll),
		.lfps_send_u1 (lfps_send_u1),
		.lfps_send_u2lb (lfps_send_u2lb),
		.lfps_send_u3 (lfps_send_u3),
		.lfps_send_ack (lfps_send_ack),
		.port_tx_elecidle (port_tx_elecidle),
		.port_tx_detrx_lpbk (port_tx_detrx_lpbk)
	);

endmodule

`default_nettype wire

// File: tb_lfps.sv
// testbench for the lfps engine that replays rx bursts and tx requests from a data file
`default_nettype none

module tb_lfps;

	logic slow_clk = 1'b0;
	logic lfps_send_reset_local;
	logic port_rx_elecidle, port_rx_valid;
	logic [1:0] port_power_state;
	logic lfps_send_poll, lfps_send_u1, lfps_send_u2lb, lfps_send_u3;
	logic lfps_send_ack, port_tx_elecidle, port_tx_detrx_lpbk;
	logic lfps_recv_active, lfps_recv_poll, lfps_recv_u1, lfps_recv_u2lb, lfps_recv_u3;
	logic [4:0] recv_vec;	// {u3, u2lb, u1, poll, active}
	logic tx_burst_on;
	int cycle_count = 0;
	int cycle_limit = 0;	// 0 until the data file is summed

	assign recv_vec = {lfps_recv_u3, lfps_recv_u2lb, lfps_recv_u1,
		lfps_recv_poll, lfps_recv_active};
	assign tx_burst_on = port_tx_detrx_lpbk | ~port_tx_elecidle;	// either signalling style

	lfps_top u_dut (.*);

	always #2 slow_clk = ~slow_clk;

	// watchdog
	always @(posedge slow_clk) begin
		cycle_count <= cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
			report_failure("run timed out, the DUT stopped making progress");
		end
	end

	//////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
			report_failure("value mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// operations
	//////////////////////////////////////////////////

	// width low samples on the line followed by gap idle cycles
	task automatic run_receive(input int width, input int gap, input string name);
		logic [4:0] exp_vec;
		exp_vec = 5'b00000;
		if (name == "poll") exp_vec = 5'b00011;
		else if (name == "u1") exp_vec = 5'b00101;
		else if (name == "u2lb") exp_vec = 5'b01001;
		else if (name == "u3") exp_vec = 5'b10001;
		else if (name != "none") report_failure({"unknown pulse name in data file: ", name});
		@(posedge slow_clk);
		port_rx_elecidle <= 1'b0;
		repeat (width) begin
			@(negedge slow_clk);
			check_value("lfps_recv_*", recv_vec, 5'b0);
		end
		@(posedge slow_clk);
		port_rx_elecidle <= 1'b1;
		// meter sees the end on the next edge and the decoder pulses one edge later
		for (int i = 1; i <= gap; i++) begin
			@(negedge slow_clk);
			check_value("lfps_recv_*", recv_vec, (i == 3) ? exp_vec : 5'b0);
		end
	endtask

	// mask bits from 0 up are poll u1 u2lb u3
	task automatic run_send(input logic [3:0] mask, input int power, input int hold,
			input int exp_width, input int exp_period);
		int width_seen;
		int period_seen;
		logic [3:0] req;
		req = mask;
		@(posedge slow_clk);
		port_power_state <= power[1:0];
		{lfps_send_u3, lfps_send_u2lb, lfps_send_u1, lfps_send_poll} <= req;
		if (hold > 0) begin
			port_rx_elecidle <= 1'b0;	// line busy with data
			port_rx_valid <= 1'b1;
			repeat (hold) begin
				@(negedge slow_clk);
				check_value("tx burst while rx busy", tx_burst_on, 1'b0);
			end
			@(posedge slow_clk);
			port_rx_elecidle <= 1'b1;
			port_rx_valid <= 1'b0;
		end
		@(negedge slow_clk);
		while (!tx_burst_on) begin
			check_value("lfps_send_ack", lfps_send_ack, 1'b0);
			@(negedge slow_clk);
		end
		width_seen = 0;
		period_seen = 0;
		while (!lfps_send_ack) begin
			if (tx_burst_on) begin
				check_value("tx burst continuity", period_seen, width_seen);
				check_value("port_tx_detrx_lpbk", port_tx_detrx_lpbk, power == 0);
				check_value("port_tx_elecidle", port_tx_elecidle, power == 0);
				width_seen++;
			end
			@(negedge slow_clk);
			period_seen++;
		end
		check_value("tx burst width", width_seen, exp_width);
		check_value("burst start to lfps_send_ack", period_seen, exp_period);
		// only the served request drops since the lowest bit has the highest priority
		@(posedge slow_clk);
		req = req & (req - 4'd1);
		{lfps_send_u3, lfps_send_u2lb, lfps_send_u1, lfps_send_poll} <= req;
		@(negedge slow_clk);
		check_value("lfps_send_ack", lfps_send_ack, 1'b0);	// ack is a single cycle
	endtask

	// first pass only sums durations for the watchdog
	task automatic process_file(input bit execute, output int total);
		int fd;
		int c;
		int a, b, d, e, f;
		string tok;
		string name;
		total = 0;
		fd = $fopen("tb_lfps_input.txt", "r");
		if (fd == 0) report_failure("could not open tb_lfps_input.txt");
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok.getc(0) == "#") begin
				c = $fgetc(fd);
				while ((c != "\n") && (c != -1)) c = $fgetc(fd);
			end else if (tok == "r") begin
				if ($fscanf(fd, "%d %d %s", a, b, name) != 3)
					report_failure("malformed receive line in data file");
				total += a + b;
				if (execute) run_receive(a, b, name);
			end else if (tok == "s") begin
				if ($fscanf(fd, "%h %d %d %d %d", a, b, d, e, f) != 5)
					report_failure("malformed send line in data file");
				total += d + e + f;
				if (execute) run_send(a[3:0], b, d, e, f);
			end else begin
				report_failure({"unknown operation in data file: ", tok});
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int total;
		lfps_send_reset_local = 1'b1;
		port_rx_elecidle = 1'b1;
		port_rx_valid = 1'b0;
		port_power_state = 2'd0;
		{lfps_send_u3, lfps_send_u2lb, lfps_send_u1, lfps_send_poll} = 4'b0;
		process_file(1'b0, total);
		cycle_limit = 2 * total + 1000;
		repeat (10) @(posedge slow_clk);
		lfps_send_reset_local <= 1'b0;
		@(negedge slow_clk);
		check_value("port_tx_elecidle", port_tx_elecidle, 1'b1);
		check_value("port_tx_detrx_lpbk", port_tx_detrx_lpbk, 1'b0);
		check_value("lfps_send_ack", lfps_send_ack, 1'b0);
		check_value("lfps_recv_*", recv_vec, 5'b0);
		process_file(1'b1, total);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_lfps_input.txt
# r <burst width> <idle gap after it> <expected pulse: none poll u1 u2lb u3>
# s <request mask hex: bit0 poll, bit1 u1, bit2 u2lb, bit3 u3> <power 0-3> <rx busy cycles> <width> <period>
# isolated bursts, one per class
r 1000 50 u1
r 20000 50 u2lb
r 200000 50 u3
# polling pairs, interval is the gap before plus the width
r 60 400 none
r 60 1000 poll
r 60 200 none
r 60 400 none
r 60 400 poll
# invalid width breaks the pair, so does u1
r 10 400 none
r 60 400 none
r 60 400 poll
r 500 400 u1
r 60 400 none
# sends, p1 then p0, u1 ahead of u3, then a busy rx line
s 1 1 0 62 625
s 1 0 0 62 625
s a 2 0 62500 62501
s 8 2 0 62500 62501
s 1 3 40 62 625

// File: flist.f
lfps_pkg.sv
lfps_burst_if.sv
lfps_burst_meter.sv
lfps_rx_decoder.sv
lfps_tx.sv
lfps_top.sv
tb_lfps.sv
